// File: common/arith_pkg.sv
// arithmetic selector types
// adder operation and twiddle factor choice

package arith_pkg;

  // fixed operation of one adder instance
  typedef enum logic {
    ADD = 1'b0,  // a + b
    SUB = 1'b1   // a - b
  } adder_op_t;

  // twiddle W^k with W = exp(-j*2*pi/8)
  typedef enum logic [1:0] {
    W0 = 2'b00,  // 1
    W1 = 2'b01,  // 0.707 - j0.707
    W2 = 2'b10,  // -j
    W3 = 2'b11   // -0.707 - j0.707
  } twiddle_sel_t;

endpackage

// File: common/fft_consts.svh
// FFT sizing constants
// sample width, frame geometry, adder blocking and ready delay

`ifndef FFT_CONSTS_SVH
`define FFT_CONSTS_SVH

// datapath
`define FFT_SAMPLE_W    16
`define FFT_POINTS      8
`define FFT_STAGES      3

// look-ahead block width inside each adder
`define FFT_CLA_BLOCK   4

// ready counter terminal value
`define FFT_READY_COUNT 3

`endif

// File: common/fft_types_pkg.sv
// FFT data types
// signed samples, complex pairs and whole frames

package fft_types_pkg;

`include "fft_consts.svh"

  // two's complement, wraps on overflow
  typedef logic signed [`FFT_SAMPLE_W-1:0] sample_t;

  // one complex point
  typedef struct packed {
    sample_t re;
    sample_t im;
  } cplx_t;

  // index 0 is sample 0
  typedef cplx_t [`FFT_POINTS-1:0] frame_t;

endpackage

// File: dv/fft_8pt_assert.sv
// assertion checker for the 8-point FFT
// mirrors capture and launch from the top ports, compares against a reference model

`timescale 1ns/1ps
`include "fft_consts.svh"

module fft_8pt_assert
  import fft_types_pkg::*;
(
  input logic   clk,
  input logic   reset_n,
  input logic   write,
  input logic   start,
  input frame_t in_frame,
  input frame_t out_frame,
  input logic   ready
);

  int     fail_count = 0;  // read by the testbench
  frame_t cap_m;
  frame_t launch_m;
  frame_t exp_s1;
  frame_t exp_s2;
  logic   started_m;

  //////////////////////////////////////////////////////////////////////
  // reference model, wraps modulo 2^16
  //////////////////////////////////////////////////////////////////////

  // 1/2 + 1/8 + 1/16 + 1/64 + 1/256 + 1/1024
  function automatic sample_t scale_root_half(sample_t x);
    sample_t lo;
    sample_t mid;
    sample_t hi;
    lo  = (x >>> 1) + (x >>> 3);
    mid = (x >>> 4) + (x >>> 6);
    hi  = (x >>> 8) + (x >>> 10);
    lo  = lo + mid;
    return lo + hi;
  endfunction

  // b times W^k
  function automatic cplx_t rotate(cplx_t b, int k);
    cplx_t   r;
    sample_t s;
    sample_t d;
    s = b.re + b.im;
    d = b.im - b.re;
    case (k)
      1:
      begin
        r.re = scale_root_half(s);
        r.im = scale_root_half(d);
      end
      2:
      begin
        r.re = b.im;
        r.im = -b.re;
      end
      3:
      begin
        r.re = scale_root_half(d);
        r.im = -scale_root_half(s);
      end
      default: r = b;
    endcase
    return r;
  endfunction

  function automatic frame_t apply_bfly(frame_t src, frame_t dst, int ia, int ib,
                                        int oa, int ob, int k);
    cplx_t bw;
    bw = rotate(src[ib], k);
    dst[oa].re = src[ia].re + bw.re;
    dst[oa].im = src[ia].im + bw.im;
    dst[ob].re = src[ia].re - bw.re;
    dst[ob].im = src[ia].im - bw.im;
    return dst;
  endfunction

  function automatic frame_t fft_model(frame_t x);
    frame_t s1;
    frame_t s2;
    frame_t s3;
    s1 = '0;
    s1 = apply_bfly(x, s1, 0, 4, 0, 1, 0);  // bit-reversed pairs
    s1 = apply_bfly(x, s1, 2, 6, 2, 3, 0);
    s1 = apply_bfly(x, s1, 1, 5, 4, 5, 0);
    s1 = apply_bfly(x, s1, 3, 7, 6, 7, 0);
    s2 = s1;
    s2 = apply_bfly(s1, s2, 0, 2, 0, 2, 0);
    s2 = apply_bfly(s1, s2, 1, 3, 1, 3, 2);
    s2 = apply_bfly(s1, s2, 4, 6, 4, 6, 0);
    s2 = apply_bfly(s1, s2, 5, 7, 5, 7, 2);
    s3 = s2;
    for (int k = 0; k < `FFT_POINTS / 2; k++)
      s3 = apply_bfly(s2, s3, k, k + 4, k, k + 4, k);
    return s3;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // port-level mirror of the front end
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      cap_m     <= '0;
      launch_m  <= '0;
      exp_s1    <= '0;
      exp_s2    <= '0;
      started_m <= 1'b0;
    end
    else
    begin
      if (write)
        cap_m <= in_frame;
      if (start)
      begin
        launch_m  <= cap_m;  // older frame when both strobes hit
        started_m <= 1'b1;
      end
      exp_s1 <= fft_model(launch_m);
      exp_s2 <= exp_s1;      // same latency as the two stage registers
    end
  end

  //////////////////////////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////////////////////////

  a_reset_state: assert property (@(posedge clk)
    (!reset_n || $rose(reset_n)) |-> (!ready && out_frame == '0))
    else begin fail_count++; $error("ERROR %0t ready or out_frame not cleared", $time); end

  // sampled one edge after the result settles
  a_launch_result: assert property (@(posedge clk) disable iff (!reset_n)
    start |-> ##3 (out_frame == exp_s2))
    else begin fail_count++; $error("ERROR %0t out_frame differs from model", $time); end

  a_out_hold: assert property (@(posedge clk) disable iff (!reset_n)
    !$past(start, 3) |-> $stable(out_frame))
    else begin fail_count++; $error("ERROR %0t out_frame moved without a launch", $time); end

  a_ready_rise: assert property (@(posedge clk) disable iff (!reset_n)
    (start && !started_m) |-> !ready [*5] ##1 ready)
    else begin fail_count++; $error("ERROR %0t ready not four edges after start", $time); end

  a_ready_early: assert property (@(posedge clk) disable iff (!reset_n)
    !started_m |-> !ready)
    else begin fail_count++; $error("ERROR %0t ready high before any launch", $time); end

  a_ready_sticky: assert property (@(posedge clk) disable iff (!reset_n)
    ready |=> ready)
    else begin fail_count++; $error("ERROR %0t ready fell without reset", $time); end

endmodule

bind fft_8pt fft_8pt_assert u_assert (
  .clk       (clk),
  .reset_n   (reset_n),
  .write     (write),
  .start     (start),
  .in_frame  (in_frame),
  .out_frame (out_frame),
  .ready     (ready)
);

// File: dv/tb_fft_8pt.sv
// testbench for the 8-point FFT
// drives capture and launch strobes, the bound checker does the comparing

`timescale 1ns/1ps
`include "fft_consts.svh"

module tb_fft_8pt
  import fft_types_pkg::*;
();

  localparam int clk_period   = 8;
  localparam int reset_cycles = 8;
  localparam int n_random     = 24;
  // reset, impulse, dc, random burst, capture only
  localparam int test_cycles  = (reset_cycles + 4) + 12 + 6 + (n_random + 5) + 10;
  localparam int watchdog_ns  = (test_cycles + 50) * clk_period;

  logic        clk;
  logic        reset_n;
  logic        write;
  logic        start;
  frame_t      in_frame;
  frame_t      out_frame;
  logic        ready;
  int          tb_errors;
  int          tests_run;
  int          prior_fails;
  logic [31:0] rng_state;
  frame_t      f;

  fft_8pt i_dut (
    .clk       (clk),
    .reset_n   (reset_n),
    .write     (write),
    .start     (start),
    .in_frame  (in_frame),
    .out_frame (out_frame),
    .ready     (ready)
  );

  always #(clk_period / 2) clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic frame_t random_frame();
    frame_t      r;
    logic [31:0] v;
    for (int k = 0; k < `FFT_POINTS; k++)
    begin
      v       = next_rand();
      r[k].re = v[15:0];   // full range, exercises wrap-around
      r[k].im = v[31:16];
    end
    return r;
  endfunction

  function automatic int total_fails();
    return tb_errors + i_dut.u_assert.fail_count;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;  // inputs move just after the edge
  endtask

  task automatic idle(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic load_frame(input frame_t fr, input logic launch);
    write    = 1'b1;
    in_frame = fr;
    start    = launch;
    next_cycle();
    write = 1'b0;
    start = 1'b0;
  endtask

  task automatic launch();
    start = 1'b1;
    next_cycle();
    start = 1'b0;
  endtask

  task automatic wait_ready(input int max_cycles);
    int n;
    n = 0;
    while (!ready && n < max_cycles)
    begin
      next_cycle();
      n++;
    end
    if (!ready)
    begin
      tb_errors++;
      $display("ready never rose within %0d cycles of the first start", max_cycles);
    end
  endtask

  task automatic end_test(input string name);
    int now_fails;
    now_fails = total_fails();
    $display("test %-14s done at %0t, failures %0d", name, $time, now_fails - prior_fails);
    prior_fails = now_fails;
    tests_run++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    clk         = 1'b0;
    reset_n     = 1'b1;
    write       = 1'b0;
    start       = 1'b0;
    in_frame    = '0;
    tb_errors   = 0;
    tests_run   = 0;
    prior_fails = 0;
    rng_state   = 32'd80622;

    #1 reset_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1 reset_n = 1'b1;
    idle(4);
    end_test("reset state");

    f    = '0;
    f[0] = '{re: 16'sd1234, im: -16'sd567};
    load_frame(f, 1'b0);
    launch();            // first launch, ready timing starts here
    wait_ready(8);
    idle(2);
    end_test("impulse");

    for (int k = 0; k < `FFT_POINTS; k++)
      f[k] = '{re: 16'sd1000, im: -16'sd300};
    load_frame(f, 1'b0);
    launch();
    idle(4);
    end_test("dc");

    // each edge captures a new frame and launches the previous one
    for (int i = 0; i < n_random; i++)
      load_frame(random_frame(), 1'b1);
    launch();
    idle(4);
    end_test("random burst");

    load_frame(random_frame(), 1'b0);
    idle(4);             // output must hold
    launch();
    idle(4);
    end_test("capture only");

    $display("summary: %0d tests, %0d failures", tests_run, total_fails());
    if (total_fails() == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  // watchdog
  initial
  begin
    #(watchdog_ns);
    $display("watchdog expired at %0t before the tests completed", $time);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: fft/butterfly_unit.sv
// radix-2 butterfly with a fixed twiddle
// x0 = a + b*W^k, x1 = a - b*W^k

`timescale 1ns/1ps

module butterfly_unit
  import fft_types_pkg::*;
  import arith_pkg::*;
#(
  parameter twiddle_sel_t tw = W0
) (
  input  cplx_t a,
  input  cplx_t b,
  output cplx_t x0,
  output cplx_t x1
);

  sample_t bw_re;
  sample_t bw_im;
  sample_t x0_re;
  sample_t x0_im;
  sample_t x1_re;
  sample_t x1_im;

  //////////////////////////////////////////////////////////////////////
  // twiddle, only the path for tw is built
  //////////////////////////////////////////////////////////////////////

  generate
    case (tw)
      W0:
      begin : g_w0
        assign bw_re = b.re;
        assign bw_im = b.im;
      end
      W2:
      begin : g_w2
        sample_t neg_re;
        cla_adder #(.op(SUB)) u_neg (.a('0), .b(b.re), .sum(neg_re));
        assign bw_re = b.im;    // times -j
        assign bw_im = neg_re;
      end
      W1, W3:
      begin : g_w13
        sample_t sum_ri;
        sample_t diff_ir;
        sample_t c_sum;
        sample_t c_diff;
        cla_adder #(.op(ADD)) u_sum (.a(b.re), .b(b.im), .sum(sum_ri));
        cla_adder #(.op(SUB)) u_diff (.a(b.im), .b(b.re), .sum(diff_ir));
        root_half_scaler u_scale_sum (.x(sum_ri), .y(c_sum));
        root_half_scaler u_scale_diff (.x(diff_ir), .y(c_diff));
        if (tw == W1)
        begin : g_w1
          assign bw_re = c_sum;
          assign bw_im = c_diff;
        end
        else
        begin : g_w3
          sample_t neg_c_sum;
          cla_adder #(.op(SUB)) u_neg (.a('0), .b(c_sum), .sum(neg_c_sum));
          assign bw_re = c_diff;
          assign bw_im = neg_c_sum;
        end
      end
    endcase
  endgenerate

  //////////////////////////////////////////////////////////////////////
  // sum and difference
  //////////////////////////////////////////////////////////////////////

  cla_adder #(.op(ADD)) u_x0_re (.a(a.re), .b(bw_re), .sum(x0_re));
  cla_adder #(.op(ADD)) u_x0_im (.a(a.im), .b(bw_im), .sum(x0_im));
  cla_adder #(.op(SUB)) u_x1_re (.a(a.re), .b(bw_re), .sum(x1_re));
  cla_adder #(.op(SUB)) u_x1_im (.a(a.im), .b(bw_im), .sum(x1_im));

  assign x0 = '{re: x0_re, im: x0_im};
  assign x1 = '{re: x1_re, im: x1_im};

endmodule

// File: fft/fft_8pt.sv
// 8-point radix-2 DIT FFT, top level
// control block followed by three butterfly stages

`timescale 1ns/1ps
`include "fft_consts.svh"

module fft_8pt
  import fft_types_pkg::*;
(
  input  logic   clk,
  input  logic   reset_n,
  input  logic   write,
  input  logic   start,
  input  frame_t in_frame,
  output frame_t out_frame,
  output logic   ready
);

  frame_t launch_frame;
  frame_t stage_frame [`FFT_STAGES+1];

  fft_control u_control (
    .clk          (clk),
    .reset_n      (reset_n),
    .write        (write),
    .start        (start),
    .in_frame     (in_frame),
    .launch_frame (launch_frame),
    .ready        (ready)
  );

  assign stage_frame[0] = launch_frame;

  genvar s;
  generate
    for (s = 0; s < `FFT_STAGES; s++)
    begin : g_stage
      // last stage drives the output directly
      fft_stage #(
        .stage      (s + 1),
        .registered (s < `FFT_STAGES - 1)
      ) u_stage (
        .clk       (clk),
        .reset_n   (reset_n),
        .stage_in  (stage_frame[s]),
        .stage_out (stage_frame[s+1])
      );
    end
  endgenerate

  assign out_frame = stage_frame[`FFT_STAGES];

endmodule

// File: fft/fft_control.sv
// FFT front end control
// frame capture on write, launch on start, ready after the first launch

`timescale 1ns/1ps
`include "fft_consts.svh"

module fft_control
  import fft_types_pkg::*;
(
  input  logic   clk,
  input  logic   reset_n,
  input  logic   write,
  input  logic   start,
  input  frame_t in_frame,
  output frame_t launch_frame,
  output logic   ready
);

  frame_t     capture_frame;
  logic       started;
  logic [1:0] ready_cnt;

  //////////////////////////////////////////////////////////////////////
  // capture and launch
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      capture_frame <= '0;
      launch_frame  <= '0;
    end
    else
    begin
      if (write)
        capture_frame <= in_frame;
      if (start)
        launch_frame <= capture_frame;  // older frame when both strobes hit
    end
  end

  //////////////////////////////////////////////////////////////////////
  // ready delay, sticky until reset
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      started   <= 1'b0;
      ready_cnt <= 2'd0;
      ready     <= 1'b0;
    end
    else
    begin
      if (start)
        started <= 1'b1;
      if (started && ready_cnt != 2'(`FFT_READY_COUNT))
        ready_cnt <= ready_cnt + 2'd1;  // saturates
      if (ready_cnt == 2'(`FFT_READY_COUNT))
        ready <= 1'b1;
    end
  end

endmodule

// File: fft/fft_stage.sv
// one FFT stage, four butterflies
// pairing and twiddles follow the stage number, optional output register

`timescale 1ns/1ps
`include "fft_consts.svh"

module fft_stage
  import fft_types_pkg::*;
  import arith_pkg::*;
#(
  parameter int stage      = 1,
  parameter bit registered = 1'b0
) (
  input  logic   clk,
  input  logic   reset_n,
  input  frame_t stage_in,
  output frame_t stage_out
);

  cplx_t  bfly_out [`FFT_POINTS];
  frame_t stage_comb;

  genvar j;
  generate
    for (j = 0; j < `FFT_POINTS / 2; j++)
    begin : g_bfly
      // stage 1 takes its pairs in bit-reversed order
      localparam int a_idx  = (stage == 1) ? (j % 2) * 2 + j / 2 :
                              (stage == 2) ? (j / 2) * 4 + j % 2 : j;
      localparam int b_idx  = a_idx + ((stage == 2) ? 2 : 4);
      localparam int x0_idx = (stage == 1) ? 2 * j : a_idx;      // later stages in place
      localparam int x1_idx = (stage == 1) ? 2 * j + 1 : b_idx;
      localparam twiddle_sel_t tw_sel = (stage == 1) ? W0 :
                                        (stage == 2) ? ((j % 2 == 1) ? W2 : W0) :
                                        twiddle_sel_t'(j);

      butterfly_unit #(.tw(tw_sel)) u_bfly (
        .a  (stage_in[a_idx]),
        .b  (stage_in[b_idx]),
        .x0 (bfly_out[x0_idx]),
        .x1 (bfly_out[x1_idx])
      );
    end
  endgenerate

  always_comb
  begin
    for (int k = 0; k < `FFT_POINTS; k++)
    begin
      stage_comb[k] = bfly_out[k];
    end
  end

  generate
    if (registered)
    begin : g_reg
      always_ff @(posedge clk or negedge reset_n)
      begin
        if (!reset_n)
        begin
          stage_out <= '0;
        end
        else
        begin
          stage_out <= stage_comb;  // loads every cycle
        end
      end
    end
    else
    begin : g_comb
      assign stage_out = stage_comb;
    end
  endgenerate

endmodule

// File: filelist.f
+incdir+common
common/fft_types_pkg.sv
common/arith_pkg.sv
logic/cla_block_4.sv
logic/cla_adder.sv
logic/root_half_scaler.sv
fft/butterfly_unit.sv
fft/fft_stage.sv
fft/fft_control.sv
fft/fft_8pt.sv
dv/fft_8pt_assert.sv
dv/tb_fft_8pt.sv

// File: logic/cla_adder.sv
// 16-bit add or subtract from chained look-ahead blocks
// a skip mux forwards the carry past fully propagating blocks

`timescale 1ns/1ps
`include "fft_consts.svh"

module cla_adder
  import fft_types_pkg::*;
  import arith_pkg::*;
#(
  parameter adder_op_t op = ADD
) (
  input  sample_t a,
  input  sample_t b,
  output sample_t sum
);

  localparam int   n_blocks = `FFT_SAMPLE_W / `FFT_CLA_BLOCK;
  localparam logic carry_in = (op == SUB);

  logic [`FFT_SAMPLE_W-1:0] b_int;
  wire  [`FFT_SAMPLE_W-1:0] sum_bits;
  wire  [n_blocks-1:0]      blk_cin;
  wire  [n_blocks-1:0]      blk_cout;
  wire  [n_blocks-1:0]      blk_prop;

  assign b_int      = b ^ {`FFT_SAMPLE_W{carry_in}};  // invert b for subtract
  assign blk_cin[0] = carry_in;                       // +1 completes the negation

  genvar i;
  generate
    for (i = 0; i < n_blocks; i++)
    begin : g_blk
      cla_block_4 u_blk (
        .a          (a[i*`FFT_CLA_BLOCK +: `FFT_CLA_BLOCK]),
        .b          (b_int[i*`FFT_CLA_BLOCK +: `FFT_CLA_BLOCK]),
        .cin        (blk_cin[i]),
        .sum        (sum_bits[i*`FFT_CLA_BLOCK +: `FFT_CLA_BLOCK]),
        .cout       (blk_cout[i]),
        .group_prop (blk_prop[i])
      );
      if (i > 0)
      begin : g_skip
        assign blk_cin[i] = blk_prop[i-1] ? blk_cin[i-1] : blk_cout[i-1];  // skip mux
      end
    end
  endgenerate

  assign sum = sum_bits;

endmodule

// File: logic/cla_block_4.sv
// 4-bit carry look-ahead block
// parallel carries plus a group propagate for the skip path

`timescale 1ns/1ps

module cla_block_4 (
  input  logic [3:0] a,
  input  logic [3:0] b,
  input  logic       cin,
  output logic [3:0] sum,
  output logic       cout,
  output logic       group_prop
);

  logic [3:0] p;
  logic [3:0] g;
  logic [3:0] c;

  assign p = a ^ b;  // propagate
  assign g = a & b;  // generate

  // carries as flat sum of products
  assign c[0] = cin;
  assign c[1] = g[0] | (p[0] & cin);
  assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
  assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
              | (p[2] & p[1] & p[0] & cin);
  assign cout = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
              | (p[3] & p[2] & p[1] & g[0]) | (p[3] & p[2] & p[1] & p[0] & cin);

  assign sum        = p ^ c;
  assign group_prop = &p;  // whole block passes cin through

endmodule

// File: logic/root_half_scaler.sv
// constant scaler, y is about 0.707 * x
// six arithmetic shifts summed in pairs by five adders

`timescale 1ns/1ps

module root_half_scaler
  import fft_types_pkg::*;
  import arith_pkg::*;
(
  input  sample_t x,
  output sample_t y
);

  // 1/2 + 1/8 + 1/16 + 1/64 + 1/256 + 1/1024
  localparam int shift_amt [6] = '{1, 3, 4, 6, 8, 10};

  sample_t shifted  [6];
  sample_t pair_sum [3];
  sample_t low_sum;

  genvar i;
  generate
    for (i = 0; i < 6; i++)
    begin : g_shift
      assign shifted[i] = x >>> shift_amt[i];  // sign extends
    end
    for (i = 0; i < 3; i++)
    begin : g_pair
      cla_adder #(.op(ADD)) u_pair (
        .a   (shifted[2*i]),
        .b   (shifted[2*i+1]),
        .sum (pair_sum[i])
      );
    end
  endgenerate

  cla_adder #(.op(ADD)) u_low (.a(pair_sum[0]), .b(pair_sum[1]), .sum(low_sum));
  cla_adder #(.op(ADD)) u_all (.a(low_sum), .b(pair_sum[2]), .sum(y));

endmodule
